//--- Makefile
TOOL     = verilator
TOP      = tb_decode_stage
FILELIST = sim.f
FLAGS    = --binary --timing --assert
LINT     = --lint-only -Wall --timing
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+src
src/decode_pkg.sv
src/instr_decoder.sv
src/reg_file_bypass.sv
src/special_regs.sv
src/int_context.sv
src/decode_stage.sv
verif/decode_stage_sva.sv
verif/tb_decode_stage.sv

//--- src/decode_defs.svh
// widths, reserved register numbers and memory base for the decode stage, included where needed
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// data path and instruction word
`define DATA_W 32

// opcode field width
`define OPC_W 5

// register selector and register count
`define REG_SEL_W 5
`define NUM_REGS 32

// flag register width
`define FL_W 2

// registers that the register file never accepts writes to
`define REG_ZERO 0
`define REG_LR 30
`define REG_FL 31

// upper half of a jump target, start of instruction memory
`define IMEM_BASE 16'h0600

`endif

//--- src/decode_pkg.sv
// opcode and state enums plus control and write structs shared by the decode stage modules
`include "decode_defs.svh"

package decode_pkg;

	// 5-bit opcode, 23..30 are illegal
	typedef enum logic [`OPC_W-1:0] {
		OP_ADD  = 5'd0,
		OP_ADDI = 5'd1,
		OP_SUB  = 5'd2,
		OP_SUBI = 5'd3,
		OP_AND  = 5'd4,
		OP_OR   = 5'd5,
		OP_XOR  = 5'd6,
		OP_NEG  = 5'd7,
		OP_SLL  = 5'd8,
		OP_SLR  = 5'd9,
		OP_SAR  = 5'd10,
		OP_LD   = 5'd11,
		OP_LDI  = 5'd12,
		OP_ST   = 5'd13,
		OP_STI  = 5'd14,
		OP_NOP  = 5'd15,
		OP_BEQ  = 5'd16,
		OP_BNE  = 5'd17,
		OP_BON  = 5'd18,
		OP_BNN  = 5'd19,
		OP_J    = 5'd20,
		OP_JR   = 5'd21,
		OP_JAL  = 5'd22,
		OP_RIN  = 5'd31
	} opcode_e;

	typedef enum logic {
		CTX_IDLE   = 1'b0,
		CTX_IN_ISR = 1'b1
	} ctx_state_e;

	// execute, memory and writeback controls
	typedef struct packed {
		logic [1:0]            alu_src;
		logic [`OPC_W-1:0]     alu_op;
		logic                  branch;
		logic                  jump;
		logic                  mem_en;
		logic                  mem_wrt;
		logic [1:0]            result_sel;
		logic                  reg_wrt_en;
		logic [`REG_SEL_W-1:0] reg_wrt_sel;
	} exec_ctrl_t;

	typedef struct packed {
		logic lr_read;
		logic lr_write;
		logic fl_read;
		logic fl_write;
	} sreg_ctrl_t;

	// one register file write
	typedef struct packed {
		logic                  en;
		logic [`REG_SEL_W-1:0] sel;
		logic [`DATA_W-1:0]    data;
	} wb_t;

	typedef struct packed {
		logic               lr_write;
		logic [`DATA_W-1:0] lr_data;
		logic               fl_write;
		logic [`FL_W-1:0]   fl_data;
	} sreg_wr_t;

endpackage

//--- src/decode_stage.sv
// decode stage top, ties decoder, register file, special registers and interrupt context together
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_stage import decode_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`DATA_W-1:0] instr,
	input  logic               flush,
	input  logic               int_req,
	input  wb_t                wb,
	input  sreg_wr_t           sreg_wr,
	output exec_ctrl_t         ctrl,
	output sreg_ctrl_t         sctrl,
	output logic [`DATA_W-1:0] imm,
	output logic [`DATA_W-1:0] rd1_data,
	output logic [`DATA_W-1:0] rd2_data,
	output logic [`DATA_W-1:0] lr,
	output logic [`FL_W-1:0]   fl,
	output logic               in_isr
);

	opcode_e opcode;
	logic restore;
	logic [`DATA_W-1:0] saved_lr;
	logic [`FL_W-1:0] saved_fl;

	instr_decoder u_dec (
		.instr  (instr),
		.flush  (flush),
		.opcode (opcode),
		.ctrl   (ctrl),
		.sctrl  (sctrl),
		.imm    (imm)
	);

	// source 1 and source 2 fields
	reg_file_bypass u_rf (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd1_sel  (instr[21:17]),
		.rd2_sel  (instr[16:12]),
		.wb       (wb),
		.rd1_data (rd1_data),
		.rd2_data (rd2_data)
	);

	special_regs u_sreg (
		.clk      (clk),
		.rst_n    (rst_n),
		.sreg_wr  (sreg_wr),
		.restore  (restore),
		.saved_lr (saved_lr),
		.saved_fl (saved_fl),
		.lr       (lr),
		.fl       (fl)
	);

	int_context u_ctx (
		.clk      (clk),
		.rst_n    (rst_n),
		.int_req  (int_req),
		.opcode   (opcode),
		.flush    (flush),
		.lr       (lr),
		.fl       (fl),
		.restore  (restore),
		.saved_lr (saved_lr),
		.saved_fl (saved_fl),
		.in_isr   (in_isr)
	);

endmodule

//--- src/instr_decoder.sv
// combinational instruction decoder producing execute/memory/writeback controls and the immediate
`timescale 1ns/1ps
`include "decode_defs.svh"

module instr_decoder import decode_pkg::*; (
	input  logic [`DATA_W-1:0] instr,
	input  logic               flush,
	output opcode_e            opcode,
	output exec_ctrl_t         ctrl,
	output sreg_ctrl_t         sctrl,
	output logic [`DATA_W-1:0] imm
);

	opcode_e op_eff;
	logic [`REG_SEL_W-1:0] dst;
	logic s1_lr;
	logic s1_fl;
	logic s2_lr;
	logic s2_fl;

	assign opcode = opcode_e'(instr[31:27]);
	// a flushed slot behaves exactly like NOP
	assign op_eff = flush ? OP_NOP : opcode;
	assign dst = instr[26:22];

	// source fields naming LR or FL
	assign s1_lr = (instr[21:17] == `REG_LR);
	assign s1_fl = (instr[21:17] == `REG_FL);
	assign s2_lr = (instr[16:12] == `REG_LR);
	assign s2_fl = (instr[16:12] == `REG_FL);

	always_comb begin
		ctrl = '0;
		ctrl.alu_src = 2'd1;
		ctrl.alu_op = op_eff;
		sctrl = '0;
		imm = '0;

		case (op_eff)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SLR, OP_SAR: begin
				ctrl.reg_wrt_en = 1'b1;
				ctrl.reg_wrt_sel = dst;
				sctrl.lr_read = s1_lr | s2_lr;
				sctrl.fl_read = s1_fl | s2_fl;
				sctrl.fl_write = 1'b1;
			end
			OP_ADDI, OP_SUBI: begin
				ctrl.alu_src = 2'd0;
				// 12-bit signed immediate
				imm = {{(`DATA_W-12){instr[11]}}, instr[11:0]};
				ctrl.reg_wrt_en = 1'b1;
				ctrl.reg_wrt_sel = dst;
				sctrl.lr_read = s1_lr;
				sctrl.fl_read = s1_fl;
				sctrl.fl_write = 1'b1;
			end
			OP_NEG: begin
				ctrl.reg_wrt_en = 1'b1;
				ctrl.reg_wrt_sel = dst;
				sctrl.lr_read = s1_lr;
				sctrl.fl_read = s1_fl;
				sctrl.fl_write = 1'b1;
			end
			OP_LD: begin
				ctrl.mem_en = 1'b1;
				ctrl.result_sel = 2'd1;
				ctrl.reg_wrt_en = 1'b1;
				ctrl.reg_wrt_sel = dst;
				sctrl.lr_read = s1_lr;
				sctrl.fl_read = s1_fl;
				sctrl.fl_write = 1'b1;
			end
			OP_LDI: begin
				ctrl.alu_src = 2'd0;
				imm = {{(`DATA_W-16){1'b0}}, instr[15:0]};
				ctrl.mem_en = 1'b1;
				ctrl.result_sel = 2'd1;
				ctrl.reg_wrt_en = 1'b1;
				ctrl.reg_wrt_sel = dst;
				sctrl.fl_write = 1'b1;
			end
			OP_ST: begin
				ctrl.mem_en = 1'b1;
				ctrl.mem_wrt = 1'b1;
				sctrl.lr_read = s1_lr;
				sctrl.fl_read = s1_fl;
			end
			OP_STI: begin
				ctrl.alu_src = 2'd0;
				imm = {{(`DATA_W-16){1'b0}}, instr[15:0]};
				ctrl.mem_en = 1'b1;
				ctrl.mem_wrt = 1'b1;
			end
			OP_NOP, OP_RIN: begin
				// no controls, RIN is handled by the interrupt context
			end
			OP_BEQ, OP_BNE, OP_BON, OP_BNN: begin
				ctrl.branch = 1'b1;
				ctrl.result_sel = 2'd2;
				sctrl.lr_read = s1_lr;
				// condition always comes from FL
				sctrl.fl_read = 1'b1;
			end
			OP_J, OP_JAL: begin
				ctrl.alu_src = 2'd0;
				ctrl.jump = 1'b1;
				ctrl.result_sel = 2'd2;
				// word index into instruction memory, byte addressed
				imm = {`IMEM_BASE, instr[13:0], 2'b00};
				sctrl.lr_write = (op_eff == OP_JAL);
			end
			OP_JR: begin
				ctrl.jump = 1'b1;
				ctrl.result_sel = 2'd2;
				sctrl.lr_read = s1_lr;
				sctrl.fl_read = s1_fl;
			end
			default: begin
				// illegal opcode, flag everything
				ctrl = '1;
				sctrl = '1;
				imm = '1;
			end
		endcase
	end

endmodule

//--- src/int_context.sv
// interrupt context FSM, saves LR/FL on entry and restores them on RIN
`timescale 1ns/1ps
`include "decode_defs.svh"

module int_context import decode_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               int_req,
	input  opcode_e            opcode,
	input  logic               flush,
	input  logic [`DATA_W-1:0] lr,
	input  logic [`FL_W-1:0]   fl,
	output logic               restore,
	output logic [`DATA_W-1:0] saved_lr,
	output logic [`FL_W-1:0]   saved_fl,
	output logic               in_isr
);

	ctx_state_e state;

	assign in_isr = (state == CTX_IN_ISR);
	// a flushed RIN is not a real return
	assign restore = in_isr && (opcode == OP_RIN) && !flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CTX_IDLE;
			saved_lr <= '0;
			saved_fl <= '0;
		end else begin
			case (state)
				CTX_IDLE: begin
					if (int_req) begin
						saved_lr <= lr;
						saved_fl <= fl;
						state <= CTX_IN_ISR;
					end
				end
				CTX_IN_ISR: begin
					// nested requests ignored
					if (restore) begin
						state <= CTX_IDLE;
					end
				end
				default: state <= CTX_IDLE;
			endcase
		end
	end

endmodule

//--- src/reg_file_bypass.sv
// 32-entry register file with write-through bypass, registers 0, 30 and 31 never written
`timescale 1ns/1ps
`include "decode_defs.svh"

module reg_file_bypass import decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`REG_SEL_W-1:0] rd1_sel,
	input  logic [`REG_SEL_W-1:0] rd2_sel,
	input  wb_t                   wb,
	output logic [`DATA_W-1:0]    rd1_data,
	output logic [`DATA_W-1:0]    rd2_data
);

	logic [`DATA_W-1:0] regs [0:`NUM_REGS-1];
	logic wr_ok;

	// zero, LR and FL slots are read-only
	assign wr_ok = wb.en
		&& (wb.sel != `REG_ZERO)
		&& (wb.sel != `REG_LR)
		&& (wb.sel != `REG_FL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wb.sel] <= wb.data;
		end
	end

	// same-cycle write forwarded to the read ports
	assign rd1_data = (wr_ok && wb.sel == rd1_sel) ? wb.data : regs[rd1_sel];
	assign rd2_data = (wr_ok && wb.sel == rd2_sel) ? wb.data : regs[rd2_sel];

endmodule

//--- src/special_regs.sv
// link register and flag register, updated from writeback or restored after an interrupt
`timescale 1ns/1ps
`include "decode_defs.svh"

module special_regs import decode_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  sreg_wr_t           sreg_wr,
	input  logic               restore,
	input  logic [`DATA_W-1:0] saved_lr,
	input  logic [`FL_W-1:0]   saved_fl,
	output logic [`DATA_W-1:0] lr,
	output logic [`FL_W-1:0]   fl
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lr <= '0;
			fl <= '0;
		end else if (restore) begin
			// return from interrupt wins over writeback
			lr <= saved_lr;
			fl <= saved_fl;
		end else begin
			if (sreg_wr.lr_write) begin
				lr <= sreg_wr.lr_data;
			end
			if (sreg_wr.fl_write) begin
				fl <= sreg_wr.fl_data;
			end
		end
	end

endmodule

//--- verif/decode_stage_sva.sv
// concurrent checks on the decode stage, attached to every decode_stage instance by bind
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_stage_sva (
	input logic               clk,
	input logic               rst_n,
	input logic [`DATA_W-1:0] instr,
	input logic               restore,
	input logic               in_isr,
	input logic [`DATA_W-1:0] rd1_data,
	input logic [`DATA_W-1:0] rd2_data
);

	logic s1_prot;
	logic s2_prot;

	// source fields naming a register that never takes a write
	assign s1_prot = (instr[21:17] == `REG_ZERO) || (instr[21:17] == `REG_LR)
		|| (instr[21:17] == `REG_FL);
	assign s2_prot = (instr[16:12] == `REG_ZERO) || (instr[16:12] == `REG_LR)
		|| (instr[16:12] == `REG_FL);

	// a return always leaves the interrupt state at the next edge
	restore_ends_isr: assert property (@(posedge clk) disable iff (!rst_n) restore |=> !in_isr)
		else $error("interrupt state not left after restore");

	prot_rd1_zero: assert property (@(posedge clk) disable iff (!rst_n) s1_prot |-> rd1_data == '0)
		else $error("protected register on read port 1 is not zero");

	prot_rd2_zero: assert property (@(posedge clk) disable iff (!rst_n) s2_prot |-> rd2_data == '0)
		else $error("protected register on read port 2 is not zero");

	restore_in_reset: assert property (@(posedge clk) !rst_n |-> !restore)
		else $error("restore raised during reset");

endmodule

bind decode_stage decode_stage_sva sva0 (
	.clk      (clk),
	.rst_n    (rst_n),
	.instr    (instr),
	.restore  (restore),
	.in_isr   (in_isr),
	.rd1_data (rd1_data),
	.rd2_data (rd2_data)
);

//--- verif/tb_decode_stage.sv
// self-checking testbench for the decode stage, run through sim.f with tb_decode_stage as top
`timescale 1ns/1ps
`include "decode_defs.svh"

module tb_decode_stage import decode_pkg::*; ();

	typedef struct packed {
		exec_ctrl_t         ctrl;
		sreg_ctrl_t         sctrl;
		logic [`DATA_W-1:0] imm;
	} dec_exp_t;

	logic               clk;
	logic               rst_n;
	logic [`DATA_W-1:0] instr;
	logic               flush;
	logic               int_req;
	wb_t                wb;
	sreg_wr_t           sreg_wr;
	exec_ctrl_t         ctrl;
	sreg_ctrl_t         sctrl;
	logic [`DATA_W-1:0] imm;
	logic [`DATA_W-1:0] rd1_data;
	logic [`DATA_W-1:0] rd2_data;
	logic [`DATA_W-1:0] lr;
	logic [`FL_W-1:0]   fl;
	logic               in_isr;

	int ctrl_errs;
	int sctrl_errs;
	int word_errs;
	int timeouts;
	logic dec_chk;
	dec_exp_t exp_dec;
	logic [`DATA_W-1:0] model_regs [0:`NUM_REGS-1];
	logic [`DATA_W-1:0] lr_m;
	logic [`DATA_W-1:0] sv_lr;
	logic [`DATA_W-1:0] wdata;
	logic [`FL_W-1:0] fl_m;
	logic [`FL_W-1:0] sv_fl;
	logic [`REG_SEL_W-1:0] wsel;
	logic [`REG_SEL_W-1:0] rsel2;
	logic accept;
	sreg_wr_t sw;

	decode_stage dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.instr    (instr),
		.flush    (flush),
		.int_req  (int_req),
		.wb       (wb),
		.sreg_wr  (sreg_wr),
		.ctrl     (ctrl),
		.sctrl    (sctrl),
		.imm      (imm),
		.rd1_data (rd1_data),
		.rd2_data (rd2_data),
		.lr       (lr),
		.fl       (fl),
		.in_isr   (in_isr)
	);

	always #10 clk = ~clk;

	// expected decoder outputs, straight from the opcode table
	function automatic dec_exp_t ref_decode(input logic [`DATA_W-1:0] ins, input logic fl_in);
		dec_exp_t e;
		int op;
		logic use1;
		logic use2;
		logic wr_dst;
		op = fl_in ? 15 : int'(ins[31:27]);
		use1 = 1'b0;
		use2 = 1'b0;
		wr_dst = 1'b0;
		e = '0;
		e.ctrl.alu_src = 2'd1;
		e.ctrl.alu_op = op[4:0];
		case (op)
			0, 2, 4, 5, 6, 8, 9, 10: begin
				wr_dst = 1'b1;
				use1 = 1'b1;
				use2 = 1'b1;
				e.sctrl.fl_write = 1'b1;
			end
			1, 3: begin
				e.ctrl.alu_src = 2'd0;
				e.imm = {{20{ins[11]}}, ins[11:0]};
				wr_dst = 1'b1;
				use1 = 1'b1;
				e.sctrl.fl_write = 1'b1;
			end
			7, 11: begin
				wr_dst = 1'b1;
				use1 = 1'b1;
				e.sctrl.fl_write = 1'b1;
				e.ctrl.mem_en = (op == 11);
				e.ctrl.result_sel = (op == 11) ? 2'd1 : 2'd0;
			end
			12, 14: begin
				e.ctrl.alu_src = 2'd0;
				e.imm = {16'h0000, ins[15:0]};
				e.ctrl.mem_en = 1'b1;
				e.ctrl.mem_wrt = (op == 14);
				e.ctrl.result_sel = (op == 12) ? 2'd1 : 2'd0;
				wr_dst = (op == 12);
				e.sctrl.fl_write = (op == 12);
			end
			13: begin
				e.ctrl.mem_en = 1'b1;
				e.ctrl.mem_wrt = 1'b1;
				use1 = 1'b1;
			end
			15, 31: begin
			end
			16, 17, 18, 19: begin
				e.ctrl.branch = 1'b1;
				e.ctrl.result_sel = 2'd2;
				e.sctrl.fl_read = 1'b1;
				use1 = 1'b1;
			end
			20, 22: begin
				e.ctrl.alu_src = 2'd0;
				e.ctrl.jump = 1'b1;
				e.ctrl.result_sel = 2'd2;
				e.imm = {`IMEM_BASE, ins[13:0], 2'b00};
				e.sctrl.lr_write = (op == 22);
			end
			21: begin
				e.ctrl.jump = 1'b1;
				e.ctrl.result_sel = 2'd2;
				use1 = 1'b1;
			end
			default: begin
				e = '1;
				return e;
			end
		endcase
		if (wr_dst) begin
			e.ctrl.reg_wrt_en = 1'b1;
			e.ctrl.reg_wrt_sel = ins[26:22];
		end
		e.sctrl.lr_read = (use1 && ins[21:17] == `REG_LR) || (use2 && ins[16:12] == `REG_LR);
		e.sctrl.fl_read = e.sctrl.fl_read || (use1 && ins[21:17] == `REG_FL)
			|| (use2 && ins[16:12] == `REG_FL);
		return e;
	endfunction

	// random fields, sources often steered onto LR or FL
	function automatic logic [`DATA_W-1:0] rand_instr(input logic [4:0] op);
		logic [`DATA_W-1:0] r;
		r = $urandom;
		r[31:27] = op;
		if ($urandom_range(0, 3) == 0) begin
			r[21:17] = 5'd30 + 5'($urandom_range(0, 1));
		end
		if ($urandom_range(0, 3) == 0) begin
			r[16:12] = 5'd30 + 5'($urandom_range(0, 1));
		end
		return r;
	endfunction

	task automatic check_ctrl(input string name, input exec_ctrl_t exp, input exec_ctrl_t act);
		if (act !== exp) begin
			ctrl_errs++;
			$display("Mismatch %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_sctrl(input string name, input sreg_ctrl_t exp, input sreg_ctrl_t act);
		if (act !== exp) begin
			sctrl_errs++;
			$display("Mismatch %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [`DATA_W-1:0] exp,
		input logic [`DATA_W-1:0] act);
		if (act !== exp) begin
			word_errs++;
			$display("Mismatch %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic wait_isr(input logic val, input int limit, input string what);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge clk);
			if (in_isr === val) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout: in_isr never reached %0b within %0d cycles (%s)", val, limit, what);
		end
	endtask

	// decoder outputs compared on every falling edge once out of reset
	always @(negedge clk) begin
		if (dec_chk) begin
			exp_dec = ref_decode(instr, flush);
			check_ctrl($sformatf("decode ctrl op %0d flush %0b", instr[31:27], flush),
				exp_dec.ctrl, ctrl);
			check_sctrl($sformatf("decode sctrl op %0d flush %0b", instr[31:27], flush),
				exp_dec.sctrl, sctrl);
			check_word($sformatf("decode imm op %0d flush %0b", instr[31:27], flush),
				exp_dec.imm, imm);
		end
	end

	initial begin
		void'($urandom(32'h0d364c26));
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		flush = 1'b0;
		int_req = 1'b0;
		wb = '0;
		sreg_wr = '0;
		dec_chk = 1'b0;
		ctrl_errs = 0;
		sctrl_errs = 0;
		word_errs = 0;
		timeouts = 0;
		lr_m = '0;
		fl_m = '0;
		for (int r = 0; r < `NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		dec_chk <= 1'b1;

		// everything cleared by reset
		@(negedge clk);
		check_word("reset lr", '0, lr);
		check_word("reset fl", '0, 32'(fl));
		check_word("reset rd1", '0, rd1_data);
		check_word("reset rd2", '0, rd2_data);
		check_word("reset in_isr", '0, 32'(in_isr));

		// all 32 opcode values, legal or not
		for (int op = 0; op < 32; op++) begin
			for (int f = 0; f < 2; f++) begin
				repeat (3) begin
					@(posedge clk);
					instr <= rand_instr(5'(op));
					flush <= f[0];
				end
			end
		end

		// register writes with same-cycle reads, protected slots forced first
		@(posedge clk);
		flush <= 1'b0;
		for (int n = 0; n < 48; n++) begin
			@(posedge clk);
			wsel = (n == 0) ? 5'd0 : (n == 1) ? 5'd30 : (n == 2) ? 5'd31 : 5'($urandom_range(0, 31));
			wdata = $urandom;
			rsel2 = 5'($urandom_range(0, 31));
			wb <= '{en: 1'b1, sel: wsel, data: wdata};
			instr <= {OP_ADD, 5'd1, wsel, rsel2, 12'h000};
			@(negedge clk);
			accept = (wsel != 5'd0) && (wsel != 5'd30) && (wsel != 5'd31);
			check_word("bypass rd1", accept ? wdata : model_regs[wsel], rd1_data);
			check_word("read rd2", (accept && rsel2 == wsel) ? wdata : model_regs[rsel2], rd2_data);
			if (accept) begin
				model_regs[wsel] = wdata;
			end
		end
		@(posedge clk);
		wb <= '0;
		for (int r = 0; r < `NUM_REGS; r++) begin
			@(posedge clk);
			instr <= {OP_ADD, 5'd1, 5'(r), 5'(31 - r), 12'h000};
			@(negedge clk);
			check_word($sformatf("readback r%0d", r), model_regs[r], rd1_data);
			check_word($sformatf("readback r%0d", 31 - r), model_regs[31 - r], rd2_data);
		end

		// LR/FL writes show up one edge later
		for (int n = 0; n < 10; n++) begin
			@(posedge clk);
			sw.lr_write = (n == 9) ? 1'b1 : 1'($urandom_range(0, 1));
			sw.lr_data = $urandom;
			sw.fl_write = (n == 9) ? 1'b1 : 1'($urandom_range(0, 1));
			sw.fl_data = 2'($urandom_range(1, 3));
			sreg_wr <= sw;
			if (sw.lr_write) begin
				lr_m = sw.lr_data;
			end
			if (sw.fl_write) begin
				fl_m = sw.fl_data;
			end
			@(posedge clk);
			sreg_wr <= '0;
			@(negedge clk);
			check_word("sreg lr", lr_m, lr);
			check_word("sreg fl", 32'(fl_m), 32'(fl));
		end

		// take the interrupt, LR/FL captured at the next edge
		@(posedge clk);
		int_req <= 1'b1;
		sv_lr = lr_m;
		sv_fl = fl_m;
		@(posedge clk);
		int_req <= 1'b0;
		wait_isr(1'b1, 4, "interrupt entry");

		// overwrite LR/FL in the handler
		@(posedge clk);
		sreg_wr <= '{lr_write: 1'b1, lr_data: ~sv_lr, fl_write: 1'b1, fl_data: ~sv_fl};
		lr_m = ~sv_lr;
		fl_m = ~sv_fl;
		// second request sees the new values and must not capture them
		@(posedge clk);
		sreg_wr <= '0;
		int_req <= 1'b1;
		@(negedge clk);
		check_word("isr lr write", lr_m, lr);
		check_word("isr fl write", 32'(fl_m), 32'(fl));
		@(posedge clk);
		int_req <= 1'b0;

		// flushed RIN is no return
		@(posedge clk);
		instr <= {OP_RIN, 27'd0};
		flush <= 1'b1;
		@(posedge clk);
		instr <= {OP_NOP, 27'd0};
		flush <= 1'b0;
		@(negedge clk);
		check_word("flushed rin lr", lr_m, lr);
		check_word("flushed rin fl", 32'(fl_m), 32'(fl));
		check_word("flushed rin in_isr", 32'd1, 32'(in_isr));

		// real RIN, a write in the same cycle loses to the restore
		@(posedge clk);
		instr <= {OP_RIN, 27'd0};
		sreg_wr <= '{lr_write: 1'b1, lr_data: sv_lr ^ 32'h5a5a_5a5a,
			fl_write: 1'b1, fl_data: ~sv_fl};
		@(posedge clk);
		instr <= {OP_NOP, 27'd0};
		sreg_wr <= '0;
		wait_isr(1'b0, 4, "return from interrupt");
		check_word("restored lr", sv_lr, lr);
		check_word("restored fl", 32'(sv_fl), 32'(fl));

		// move LR/FL away from the saved copies first
		@(posedge clk);
		sreg_wr <= '{lr_write: 1'b1, lr_data: ~sv_lr, fl_write: 1'b1, fl_data: ~sv_fl};
		lr_m = ~sv_lr;
		fl_m = ~sv_fl;

		// RIN outside an interrupt leaves LR/FL alone
		@(posedge clk);
		sreg_wr <= '0;
		instr <= {OP_RIN, 27'd0};
		@(posedge clk);
		instr <= {OP_NOP, 27'd0};
		@(negedge clk);
		check_word("idle rin lr", lr_m, lr);
		check_word("idle rin fl", 32'(fl_m), 32'(fl));
		check_word("idle rin in_isr", '0, 32'(in_isr));

		repeat (2) @(posedge clk);
		$display("error counts: ctrl %0d sctrl %0d word %0d timeout %0d",
			ctrl_errs, sctrl_errs, word_errs, timeouts);
		if (ctrl_errs + sctrl_errs + word_errs + timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
